// ==== dv/fpu_mul_sva.sv ====
/* fp multiplier checks
   latency, flags, exponent, fraction, tiny results and stall */
`timescale 1ns/1ps
`include "fpu_mul_consts.svh"

module fpu_mul_sva (
  input logic                        clk,
  input logic                        rst,
  input logic                        flush_i,
  input logic                        adv_i,
  input logic                        start_i,
  input logic                        sign_a_i,
  input logic                        sign_b_i,
  input logic [`FPU_EXP_W-1:0]       exp_a_i,
  input logic [`FPU_EXP_W-1:0]       exp_b_i,
  input logic [`FPU_FRACT_W-1:0]     fract_a_i,
  input logic [`FPU_FRACT_W-1:0]     fract_b_i,
  input logic                        inf_a_i,
  input logic                        inf_b_i,
  input logic                        zero_a_i,
  input logic                        zero_b_i,
  input logic                        snan_i,
  input logic                        qnan_i,
  input logic                        anan_sign_i,
  input logic                        rdy_o,
  input logic                        sign_o,
  input logic [`FPU_LZC_W-1:0]       shr_o,
  input logic [`FPU_EXP_W-1:0]       exp10shr_o,
  input logic [`FPU_EXP_W-1:0]       exp10sh0_o,
  input logic [`FPU_OUT_FRACT_W-1:0] fract28_o,
  input logic                        inv_o,
  input logic                        inf_o,
  input logic                        snan_o,
  input logic                        qnan_o,
  input logic                        anan_sign_o
);

  int fail_cnt = 0;

  ////////////////////////////////////////
  // input history with [3] four edges back
  ////////////////////////////////////////
  logic [3:0]                       adv_q, flush_q, start_q, sign_q, inv_q, inf_q;
  logic [3:0]                       zero_q, norm_q;
  logic [3:0][2:0]                  nan_q;
  logic [3:0][`FPU_EXP_W-1:0]       e_q;
  logic [3:0][2*`FPU_FRACT_W-1:0]   prod_q;

  always_ff @(posedge clk) begin
    adv_q   <= {adv_q[2:0], adv_i};
    flush_q <= {flush_q[2:0], flush_i};
    start_q <= {start_q[2:0], start_i};
    sign_q  <= {sign_q[2:0], sign_a_i ^ sign_b_i};
    // zero times infinity
    inv_q   <= {inv_q[2:0], (zero_a_i & inf_b_i) | (zero_b_i & inf_a_i)};
    inf_q   <= {inf_q[2:0], inf_a_i | inf_b_i};
    nan_q   <= {nan_q[2:0], {snan_i, qnan_i, anan_sign_i}};
    zero_q  <= {zero_q[2:0], zero_a_i | zero_b_i};
    norm_q  <= {norm_q[2:0], fract_a_i[`FPU_FRACT_W-1] & fract_b_i[`FPU_FRACT_W-1]
                             & ~zero_a_i & ~zero_b_i};
    // biased sum wraps modulo 1024
    e_q     <= {e_q[2:0], `FPU_EXP_W'(exp_a_i + exp_b_i - `FPU_BIAS)};
    prod_q  <= {prod_q[2:0], (2*`FPU_FRACT_W)'(fract_a_i) * (2*`FPU_FRACT_W)'(fract_b_i)};
  end

  logic                        live, item;
  logic                        rdy_exp;
  logic [5:0]                  flags_exp, flags_act;
  logic [`FPU_OUT_FRACT_W-1:0] fract_exp;
  logic [`FPU_EXP_W-1:0]       shr_raw;
  logic [`FPU_LZC_W-1:0]       shr_exp;
  logic [`FPU_OUT_FRACT_W+2*`FPU_EXP_W+`FPU_LZC_W-1:0] zero_act;

  // four advancing edges in a row
  assign live      = &adv_q;
  assign item      = live & start_q[3];
  assign rdy_exp   = start_q[3] & ~|flush_q;
  assign flags_exp = {sign_q[3], inv_q[3], inf_q[3], nan_q[3]};
  assign flags_act = {sign_o, inv_o, inf_o, snan_o, qnan_o, anan_sign_o};
  // top 27 product bits plus sticky
  assign fract_exp = {prod_q[3][2*`FPU_FRACT_W-1:21], |prod_q[3][20:0]};
  assign shr_raw   = `FPU_EXP_W'(1025 - e_q[3]);
  assign shr_exp   = (shr_raw > `FPU_SHR_MAX) ? `FPU_LZC_W'(`FPU_SHR_MAX)
                                              : shr_raw[`FPU_LZC_W-1:0];
  // fraction, exponents and shift of a zero result
  assign zero_act  = {fract28_o, exp10sh0_o, exp10shr_o, shr_o};

  a_latency: assert property (@(posedge clk) disable iff (rst) live |-> rdy_o == rdy_exp)
    else begin
      $error("Fail latency: expected %0b actual %0b", $sampled(rdy_exp), $sampled(rdy_o));
      fail_cnt++;
    end

  a_flags: assert property (@(posedge clk) disable iff (rst) item |-> flags_act == flags_exp)
    else begin
      $error("Fail flags: expected %h actual %h", $sampled(flags_exp), $sampled(flags_act));
      fail_cnt++;
    end

  a_exp: assert property (@(posedge clk) disable iff (rst)
    item && norm_q[3] |-> exp10sh0_o == e_q[3])
    else begin
      $error("Fail exponent: expected %h actual %h", $sampled(e_q[3]), $sampled(exp10sh0_o));
      fail_cnt++;
    end

  a_fract: assert property (@(posedge clk) disable iff (rst)
    item && norm_q[3] |-> fract28_o == fract_exp)
    else begin
      $error("Fail fraction: expected %h actual %h", $sampled(fract_exp), $sampled(fract28_o));
      fail_cnt++;
    end

  a_zero: assert property (@(posedge clk) disable iff (rst)
    item && zero_q[3] |-> zero_act == '0)
    else begin
      $error("Fail zero: expected 0 actual %h", $sampled(zero_act));
      fail_cnt++;
    end

  // negative or zero sum shifts right with exponent 1
  a_tiny: assert property (@(posedge clk) disable iff (rst)
    item && norm_q[3] && (e_q[3][`FPU_EXP_W-1] || e_q[3] == '0)
    |-> exp10shr_o == 1 && shr_o == shr_exp)
    else begin
      $error("Fail tiny: expected exp 1 shift %0d actual exp %0d shift %0d",
             $sampled(shr_exp), $sampled(exp10shr_o), $sampled(shr_o));
      fail_cnt++;
    end

  a_stall: assert property (@(posedge clk) disable iff (rst)
    !adv_q[0] |-> $stable({rdy_o, flags_act, shr_o, exp10shr_o, exp10sh0_o, fract28_o}))
    else begin
      $error("outputs changed while adv_i was low");
      fail_cnt++;
    end

endmodule

bind fpu_mul_top fpu_mul_sva u_sva (.*);

// ==== dv/fpu_mul_tb.sv ====
/* fp multiplier testbench
   random operands, flush and stall phases, ready counting */
`timescale 1ns/1ps
`include "fpu_mul_consts.svh"

module fpu_mul_tb;

  localparam int N_VEC    = 240;
  localparam int CLK_NS   = 4;
  localparam int LIMIT_NS = (N_VEC * 4 + 100) * CLK_NS;

  logic                        clk = 1'b0;
  logic                        rst, flush_i, adv_i, start_i;
  logic                        sign_a_i, sign_b_i, inf_a_i, inf_b_i, zero_a_i, zero_b_i;
  logic                        snan_i, qnan_i, anan_sign_i;
  logic [`FPU_EXP_W-1:0]       exp_a_i, exp_b_i;
  logic [`FPU_FRACT_W-1:0]     fract_a_i, fract_b_i;
  logic                        rdy_o, sign_o, inv_o, inf_o, snan_o, qnan_o, anan_sign_o;
  logic [`FPU_LZC_W-1:0]       shr_o;
  logic [`FPU_EXP_W-1:0]       exp10shr_o, exp10sh0_o;
  logic [`FPU_OUT_FRACT_W-1:0] fract28_o;

  logic [15:0] lfsr = 16'd53004;
  int          expected = 0;
  int          rdy_cnt = 0;
  int          errors = 0;

  fpu_mul_top DUT (.*);

  always #(CLK_NS / 2) clk = ~clk;

  // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #0.5;
  endtask

  ////////////////////////////////////////
  // operand kinds
  // 0 normal, 1 denormal, 2 zero, 3 inf, 4 zero*inf, 5 tiny
  ////////////////////////////////////////
  task automatic issue(input int kind);
    logic [31:0] r;
    next_cycle();
    take_bits(kind == 1 ? 20 : 23, r);
    fract_a_i = (kind == 1) ? r[23:0] : {1'b1, r[22:0]};
    take_bits(kind == 1 ? 20 : 23, r);
    fract_b_i = (kind == 1) ? r[23:0] : {1'b1, r[22:0]};
    // small exponents reach negative sums
    take_bits(kind == 5 ? 6 : 8, r);
    exp_a_i = r[`FPU_EXP_W-1:0];
    take_bits(kind == 5 ? 6 : 8, r);
    exp_b_i = r[`FPU_EXP_W-1:0];
    if (kind == 5 && r[0]) begin
      // sum lands exactly on zero
      exp_b_i = `FPU_EXP_W'(`FPU_BIAS) - exp_a_i;
    end
    take_bits(5, r);
    {sign_a_i, sign_b_i, snan_i, qnan_i, anan_sign_i} = r[4:0];
    take_bits(2, r);
    zero_a_i = (kind == 2 || kind == 4) & r[0];
    zero_b_i = (kind == 2 || kind == 4) & ~r[0];
    inf_a_i  = (kind == 3 & r[1]) | (kind == 4 & ~r[0]);
    inf_b_i  = (kind == 3 & ~r[1]) | (kind == 4 & r[0]);
    start_i  = 1'b1;
    expected++;
  endtask

  // three items in flight, all killed by the flush
  task automatic flush_burst();
    repeat (3) issue(0);
    next_cycle();
    start_i = 1'b0;
    flush_i = 1'b1;
    next_cycle();
    flush_i = 1'b0;
    expected -= 3;
  endtask

  task automatic stall(input int n);
    next_cycle();
    start_i = 1'b0;
    adv_i   = 1'b0;
    repeat (n) next_cycle();
    adv_i   = 1'b1;
  endtask

  // an item leaves at the next edge when adv_i is high
  always @(negedge clk) begin
    if (!rst && rdy_o && adv_i) begin
      rdy_cnt++;
    end
  end

  initial begin
    #(LIMIT_NS);
    $display("timeout: run did not finish within %0d ns", LIMIT_NS);
    $display("Test failures found");
    $finish;
  end

  initial begin
    rst = 1'b1;
    flush_i = 1'b0;
    // pipe keeps loading during reset so no data register stays unknown
    adv_i = 1'b1;
    start_i = 1'b0;
    {sign_a_i, sign_b_i, inf_a_i, inf_b_i, zero_a_i, zero_b_i} = '0;
    {snan_i, qnan_i, anan_sign_i} = '0;
    exp_a_i = '0;
    exp_b_i = '0;
    fract_a_i = '0;
    fract_b_i = '0;
    repeat (3) @(posedge clk);
    #0.5;
    rst = 1'b0;
    for (int i = 0; i < N_VEC; i++) begin
      issue(i % 6);
      if (i % 60 == 30) begin
        flush_burst();
      end
      if (i % 60 == 59) begin
        stall(5);
      end
    end
    next_cycle();
    start_i = 1'b0;
    // latency is fixed at four advancing edges
    repeat (8) next_cycle();
    if (rdy_cnt != expected) begin
      $display("Fail ready_count: expected %0d actual %0d", expected, rdy_cnt);
      errors++;
    end
    $display("errors: %0d count mismatches, %0d assertion failures",
             errors, DUT.u_sva.fail_cnt);
    if (errors == 0 && DUT.u_sva.fail_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+rtl
rtl/fpu_mul_pkg.sv
rtl/fpu_mul_prenorm.sv
rtl/fpu_mul_normalize.sv
rtl/fpu_mul_partial.sv
rtl/fpu_mul_sum.sv
rtl/fpu_mul_top.sv
dv/fpu_mul_sva.sv
dv/fpu_mul_tb.sv

// ==== rtl/fpu_mul_consts.svh ====
/* fp multiplier front end
   widths, exponent bias and shift saturation */
`ifndef FPU_MUL_CONSTS_SVH
`define FPU_MUL_CONSTS_SVH

// unpacked operand fields
`define FPU_EXP_W        10
`define FPU_FRACT_W      24

// leading-zero count, also used for the align shift amount
`define FPU_LZC_W        5

// multiplier operands and half-words
`define FPU_HALF_W       16
`define FPU_OPND_W       32

// fraction to align/round, {27 bits, sticky}
`define FPU_OUT_FRACT_W  28

`define FPU_BIAS         127
`define FPU_SHR_MAX      31

`endif

// ==== rtl/fpu_mul_normalize.sv ====
/* fp multiplier stage 1
   fraction normalisation and biased exponent sum */
`timescale 1ns/1ps
`include "fpu_mul_consts.svh"

module fpu_mul_normalize import fpu_mul_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    flush_i,
  input  logic                    adv_i,
  input  logic                    rdy_i,
  input  logic [`FPU_EXP_W-1:0]   exp_a_i,
  input  logic [`FPU_EXP_W-1:0]   exp_b_i,
  input  logic [`FPU_FRACT_W-1:0] fract_a_i,
  input  logic [`FPU_FRACT_W-1:0] fract_b_i,
  input  logic [`FPU_LZC_W-1:0]   nlz_a_i,
  input  logic [`FPU_LZC_W-1:0]   nlz_b_i,
  input  logic                    opc_0_i,
  input  logic                    sign_i,
  input  logic                    inv_i,
  input  logic                    inf_i,
  input  logic                    snan_i,
  input  logic                    qnan_i,
  input  logic                    anan_sign_i,
  output logic                    rdy_o,
  output mul_operand_u            opnd_a_o,
  output mul_operand_u            opnd_b_o,
  output logic [`FPU_EXP_W-1:0]   exp_o,
  output logic                    opc_0_o,
  output logic                    sign_o,
  output logic                    inv_o,
  output logic                    inf_o,
  output logic                    snan_o,
  output logic                    qnan_o,
  output logic                    anan_sign_o
);

  localparam int PAD_W = `FPU_OPND_W - `FPU_FRACT_W;
  localparam int EXT_W = `FPU_EXP_W - `FPU_LZC_W;
  localparam logic [`FPU_EXP_W-1:0] BIAS = `FPU_BIAS;

  logic [`FPU_FRACT_W-1:0] fract_a_n;
  logic [`FPU_FRACT_W-1:0] fract_b_n;
  logic [`FPU_EXP_W-1:0]   exp_sum;

  // msb to bit 23, cleared for a zero result
  assign fract_a_n = (fract_a_i << nlz_a_i) & {`FPU_FRACT_W{~opc_0_i}};
  assign fract_b_n = (fract_b_i << nlz_b_i) & {`FPU_FRACT_W{~opc_0_i}};

  // ea + eb - nlz_a - nlz_b - bias, wraps negative
  assign exp_sum = exp_a_i + exp_b_i - {{EXT_W{1'b0}}, nlz_a_i}
                 - {{EXT_W{1'b0}}, nlz_b_i} - BIAS;

  always_ff @(posedge clk) begin
    if (adv_i) begin
      opnd_a_o.word <= {fract_a_n, {PAD_W{1'b0}}};
      opnd_b_o.word <= {fract_b_n, {PAD_W{1'b0}}};
      exp_o         <= exp_sum & {`FPU_EXP_W{~opc_0_i}};
      opc_0_o       <= opc_0_i;
      sign_o        <= sign_i;
      inv_o         <= inv_i;
      inf_o         <= inf_i;
      snan_o        <= snan_i;
      qnan_o        <= qnan_i;
      anan_sign_o   <= anan_sign_i;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rdy_o <= 1'b0;
    end else if (flush_i) begin
      rdy_o <= 1'b0;
    end else if (adv_i) begin
      rdy_o <= rdy_i;
    end
  end

endmodule

// ==== rtl/fpu_mul_partial.sv ====
/* fp multiplier stage 2
   16x16 partial products and right shift for tiny exponents */
`timescale 1ns/1ps
`include "fpu_mul_consts.svh"

module fpu_mul_partial import fpu_mul_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    flush_i,
  input  logic                    adv_i,
  input  logic                    rdy_i,
  input  mul_operand_u            opnd_a_i,
  input  mul_operand_u            opnd_b_i,
  input  logic [`FPU_EXP_W-1:0]   exp_i,
  input  logic                    opc_0_i,
  input  logic                    sign_i,
  input  logic                    inv_i,
  input  logic                    inf_i,
  input  logic                    snan_i,
  input  logic                    qnan_i,
  input  logic                    anan_sign_i,
  output logic                    rdy_o,
  output logic [2*`FPU_HALF_W-1:0] pp_ll_o,
  output logic [2*`FPU_HALF_W-1:0] pp_lh_o,
  output logic [2*`FPU_HALF_W-1:0] pp_hl_o,
  output logic [2*`FPU_HALF_W-1:0] pp_hh_o,
  output logic [`FPU_LZC_W-1:0]   shr_o,
  output logic [`FPU_EXP_W-1:0]   exp10rx_o,
  output logic [`FPU_EXP_W-1:0]   exp10c_o,
  output logic                    sign_o,
  output logic                    inv_o,
  output logic                    inf_o,
  output logic                    snan_o,
  output logic                    qnan_o,
  output logic                    anan_sign_o
);

  localparam logic [`FPU_EXP_W-1:0] EXP_ONE = 1;
  localparam logic [`FPU_LZC_W-1:0] SHR_MAX = `FPU_SHR_MAX;

  logic [`FPU_EXP_W-1:0] shr_neg;
  logic [`FPU_LZC_W-1:0] shr_t;
  logic [`FPU_EXP_W-1:0] exp_rx;

  // 1024 - e + 1, the 1024 drops out of the 10-bit wrap
  assign shr_neg = EXP_ONE - exp_i;

  ////////////////////////////////////////
  // right shift decision
  ////////////////////////////////////////

  always_comb begin
    if (opc_0_i) begin
      shr_t  = '0;
      exp_rx = '0;
    end else if (exp_i[`FPU_EXP_W-1]) begin
      // negative sum, beyond 31 everything is sticky anyway
      shr_t  = (shr_neg > `FPU_EXP_W'(SHR_MAX)) ? SHR_MAX : shr_neg[`FPU_LZC_W-1:0];
      exp_rx = EXP_ONE;
    end else if (exp_i == '0) begin
      // potential denormal
      shr_t  = 1;
      exp_rx = EXP_ONE;
    end else begin
      shr_t  = '0;
      exp_rx = exp_i;
    end
  end

  always_ff @(posedge clk) begin
    if (adv_i) begin
      pp_ll_o     <= opnd_a_i.halves.lo * opnd_b_i.halves.lo;
      pp_lh_o     <= opnd_a_i.halves.lo * opnd_b_i.halves.hi;
      pp_hl_o     <= opnd_a_i.halves.hi * opnd_b_i.halves.lo;
      pp_hh_o     <= opnd_a_i.halves.hi * opnd_b_i.halves.hi;
      shr_o       <= shr_t;
      exp10rx_o   <= exp_rx;
      exp10c_o    <= exp_i;
      sign_o      <= sign_i;
      inv_o       <= inv_i;
      inf_o       <= inf_i;
      snan_o      <= snan_i;
      qnan_o      <= qnan_i;
      anan_sign_o <= anan_sign_i;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rdy_o <= 1'b0;
    end else if (flush_i) begin
      rdy_o <= 1'b0;
    end else if (adv_i) begin
      rdy_o <= rdy_i;
    end
  end

endmodule

// ==== rtl/fpu_mul_pkg.sv ====
/* fp multiplier types
   operand word and its half-word view */
`include "fpu_mul_consts.svh"

package fpu_mul_pkg;

  // half-words feeding the 16x16 multipliers
  typedef struct packed {
    logic [`FPU_HALF_W-1:0] hi;
    logic [`FPU_HALF_W-1:0] lo;
  } mul_halves_t;

  // normalised fraction padded with zeros, or split in halves
  typedef union packed {
    logic [`FPU_OPND_W-1:0] word;
    mul_halves_t            halves;
  } mul_operand_u;

endpackage

// ==== rtl/fpu_mul_prenorm.sv ====
/* fp multiplier stage 0
   leading-zero counts, exception flags and input register */
`timescale 1ns/1ps
`include "fpu_mul_consts.svh"

module fpu_mul_prenorm (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    flush_i,
  input  logic                    adv_i,
  input  logic                    start_i,
  input  logic                    sign_a_i,
  input  logic                    sign_b_i,
  input  logic [`FPU_EXP_W-1:0]   exp_a_i,
  input  logic [`FPU_EXP_W-1:0]   exp_b_i,
  input  logic [`FPU_FRACT_W-1:0] fract_a_i,
  input  logic [`FPU_FRACT_W-1:0] fract_b_i,
  input  logic                    inf_a_i,
  input  logic                    inf_b_i,
  input  logic                    zero_a_i,
  input  logic                    zero_b_i,
  input  logic                    snan_i,
  input  logic                    qnan_i,
  input  logic                    anan_sign_i,
  output logic                    rdy_o,
  output logic                    sign_o,
  output logic [`FPU_EXP_W-1:0]   exp_a_o,
  output logic [`FPU_EXP_W-1:0]   exp_b_o,
  output logic [`FPU_FRACT_W-1:0] fract_a_o,
  output logic [`FPU_FRACT_W-1:0] fract_b_o,
  output logic [`FPU_LZC_W-1:0]   nlz_a_o,
  output logic [`FPU_LZC_W-1:0]   nlz_b_o,
  output logic                    opc_0_o,
  output logic                    inv_o,
  output logic                    inf_o,
  output logic                    snan_o,
  output logic                    qnan_o,
  output logic                    anan_sign_o
);

  // priority count, highest set bit wins
  // all-zero fraction counts as 0
  function automatic logic [`FPU_LZC_W-1:0] lzc(input logic [`FPU_FRACT_W-1:0] f);
    logic [`FPU_LZC_W-1:0] n;
    n = '0;
    for (int i = 0; i < `FPU_FRACT_W; i++) begin
      if (f[i]) n = `FPU_LZC_W'(`FPU_FRACT_W - 1 - i);
    end
    return n;
  endfunction

  ////////////////////////////////////////
  // stage 0 register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (adv_i) begin
      // 0 * inf is invalid
      inv_o       <= (zero_a_i & inf_b_i) | (zero_b_i & inf_a_i);
      inf_o       <= inf_a_i | inf_b_i;
      snan_o      <= snan_i;
      qnan_o      <= qnan_i;
      anan_sign_o <= anan_sign_i;
      // any zero input forces a zero result
      opc_0_o     <= zero_a_i | zero_b_i;
      sign_o      <= sign_a_i ^ sign_b_i;
      exp_a_o     <= exp_a_i;
      exp_b_o     <= exp_b_i;
      fract_a_o   <= fract_a_i;
      fract_b_o   <= fract_b_i;
      nlz_a_o     <= lzc(fract_a_i);
      nlz_b_o     <= lzc(fract_b_i);
    end
  end

  // ready travels beside the data
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rdy_o <= 1'b0;
    end else if (flush_i) begin
      rdy_o <= 1'b0;
    end else if (adv_i) begin
      rdy_o <= start_i;
    end
  end

endmodule

// ==== rtl/fpu_mul_sum.sv ====
/* fp multiplier stage 3
   partial-product sum, sticky bit and output register */
`timescale 1ns/1ps
`include "fpu_mul_consts.svh"

module fpu_mul_sum (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        flush_i,
  input  logic                        adv_i,
  input  logic                        rdy_i,
  input  logic [2*`FPU_HALF_W-1:0]    pp_ll_i,
  input  logic [2*`FPU_HALF_W-1:0]    pp_lh_i,
  input  logic [2*`FPU_HALF_W-1:0]    pp_hl_i,
  input  logic [2*`FPU_HALF_W-1:0]    pp_hh_i,
  input  logic [`FPU_LZC_W-1:0]       shr_i,
  input  logic [`FPU_EXP_W-1:0]       exp10rx_i,
  input  logic [`FPU_EXP_W-1:0]       exp10c_i,
  input  logic                        sign_i,
  input  logic                        inv_i,
  input  logic                        inf_i,
  input  logic                        snan_i,
  input  logic                        qnan_i,
  input  logic                        anan_sign_i,
  output logic                        rdy_o,
  output logic                        sign_o,
  output logic [`FPU_LZC_W-1:0]       shr_o,
  output logic [`FPU_EXP_W-1:0]       exp10shr_o,
  output logic [`FPU_EXP_W-1:0]       exp10sh0_o,
  output logic [`FPU_OUT_FRACT_W-1:0] fract28_o,
  output logic                        inv_o,
  output logic                        inf_o,
  output logic                        snan_o,
  output logic                        qnan_o,
  output logic                        anan_sign_o
);

  localparam int PROD_W = 2 * `FPU_FRACT_W;
  localparam int KEEP_W = `FPU_OUT_FRACT_W - 1;
  localparam int HW     = `FPU_HALF_W;

  logic [PROD_W-1:0] fract48;
  logic              sticky;

  // upper 48 bits of the 64-bit product, ll low half only feeds sticky
  assign fract48 = {pp_hh_i, {HW{1'b0}}}
                 + {{HW{1'b0}}, pp_hl_i}
                 + {{HW{1'b0}}, pp_lh_i}
                 + {{(PROD_W-HW){1'b0}}, pp_ll_i[2*HW-1:HW]};

  assign sticky = (|fract48[PROD_W-KEEP_W-1:0]) | (|pp_ll_i[HW-1:0]);

  always_ff @(posedge clk) begin
    if (adv_i) begin
      fract28_o   <= {fract48[PROD_W-1 -: KEEP_W], sticky};
      shr_o       <= shr_i;
      exp10shr_o  <= exp10rx_i;
      exp10sh0_o  <= exp10c_i;
      sign_o      <= sign_i;
      inv_o       <= inv_i;
      inf_o       <= inf_i;
      snan_o      <= snan_i;
      qnan_o      <= qnan_i;
      anan_sign_o <= anan_sign_i;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rdy_o <= 1'b0;
    end else if (flush_i) begin
      rdy_o <= 1'b0;
    end else if (adv_i) begin
      rdy_o <= rdy_i;
    end
  end

endmodule

// ==== rtl/fpu_mul_top.sv ====
/* fp multiplier front end, four stages
   prenorm, normalise, partial products, sum */
`timescale 1ns/1ps
`include "fpu_mul_consts.svh"

module fpu_mul_top import fpu_mul_pkg::*; (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        flush_i,
  input  logic                        adv_i,
  input  logic                        start_i,
  input  logic                        sign_a_i,
  input  logic                        sign_b_i,
  input  logic [`FPU_EXP_W-1:0]       exp_a_i,
  input  logic [`FPU_EXP_W-1:0]       exp_b_i,
  input  logic [`FPU_FRACT_W-1:0]     fract_a_i,
  input  logic [`FPU_FRACT_W-1:0]     fract_b_i,
  input  logic                        inf_a_i,
  input  logic                        inf_b_i,
  input  logic                        zero_a_i,
  input  logic                        zero_b_i,
  input  logic                        snan_i,
  input  logic                        qnan_i,
  input  logic                        anan_sign_i,
  output logic                        rdy_o,
  output logic                        sign_o,
  output logic [`FPU_LZC_W-1:0]       shr_o,
  output logic [`FPU_EXP_W-1:0]       exp10shr_o,
  output logic [`FPU_EXP_W-1:0]       exp10sh0_o,
  output logic [`FPU_OUT_FRACT_W-1:0] fract28_o,
  output logic                        inv_o,
  output logic                        inf_o,
  output logic                        snan_o,
  output logic                        qnan_o,
  output logic                        anan_sign_o
);

  ////////////////////////////////////////
  // stage 0 -> 1
  ////////////////////////////////////////
  logic                    s0_rdy, s0_sign, s0_opc_0;
  logic                    s0_inv, s0_inf, s0_snan, s0_qnan, s0_anan;
  logic [`FPU_EXP_W-1:0]   s0_exp_a, s0_exp_b;
  logic [`FPU_FRACT_W-1:0] s0_fract_a, s0_fract_b;
  logic [`FPU_LZC_W-1:0]   s0_nlz_a, s0_nlz_b;

  ////////////////////////////////////////
  // stage 1 -> 2
  ////////////////////////////////////////
  logic                    s1_rdy, s1_sign, s1_opc_0;
  logic                    s1_inv, s1_inf, s1_snan, s1_qnan, s1_anan;
  mul_operand_u            s1_opnd_a, s1_opnd_b;
  logic [`FPU_EXP_W-1:0]   s1_exp;

  ////////////////////////////////////////
  // stage 2 -> 3
  ////////////////////////////////////////
  logic                     s2_rdy, s2_sign;
  logic                     s2_inv, s2_inf, s2_snan, s2_qnan, s2_anan;
  logic [2*`FPU_HALF_W-1:0] s2_pp_ll, s2_pp_lh, s2_pp_hl, s2_pp_hh;
  logic [`FPU_LZC_W-1:0]    s2_shr;
  logic [`FPU_EXP_W-1:0]    s2_exp10rx, s2_exp10c;

  fpu_mul_prenorm u_prenorm (
    .clk, .rst, .flush_i, .adv_i, .start_i,
    .sign_a_i, .sign_b_i, .exp_a_i, .exp_b_i, .fract_a_i, .fract_b_i,
    .inf_a_i, .inf_b_i, .zero_a_i, .zero_b_i, .snan_i, .qnan_i, .anan_sign_i,
    .rdy_o(s0_rdy), .sign_o(s0_sign), .exp_a_o(s0_exp_a), .exp_b_o(s0_exp_b),
    .fract_a_o(s0_fract_a), .fract_b_o(s0_fract_b),
    .nlz_a_o(s0_nlz_a), .nlz_b_o(s0_nlz_b), .opc_0_o(s0_opc_0),
    .inv_o(s0_inv), .inf_o(s0_inf), .snan_o(s0_snan), .qnan_o(s0_qnan),
    .anan_sign_o(s0_anan)
  );

  fpu_mul_normalize u_normalize (
    .clk, .rst, .flush_i, .adv_i, .rdy_i(s0_rdy),
    .exp_a_i(s0_exp_a), .exp_b_i(s0_exp_b),
    .fract_a_i(s0_fract_a), .fract_b_i(s0_fract_b),
    .nlz_a_i(s0_nlz_a), .nlz_b_i(s0_nlz_b), .opc_0_i(s0_opc_0), .sign_i(s0_sign),
    .inv_i(s0_inv), .inf_i(s0_inf), .snan_i(s0_snan), .qnan_i(s0_qnan),
    .anan_sign_i(s0_anan),
    .rdy_o(s1_rdy), .opnd_a_o(s1_opnd_a), .opnd_b_o(s1_opnd_b), .exp_o(s1_exp),
    .opc_0_o(s1_opc_0), .sign_o(s1_sign), .inv_o(s1_inv), .inf_o(s1_inf),
    .snan_o(s1_snan), .qnan_o(s1_qnan), .anan_sign_o(s1_anan)
  );

  fpu_mul_partial u_partial (
    .clk, .rst, .flush_i, .adv_i, .rdy_i(s1_rdy),
    .opnd_a_i(s1_opnd_a), .opnd_b_i(s1_opnd_b), .exp_i(s1_exp),
    .opc_0_i(s1_opc_0), .sign_i(s1_sign), .inv_i(s1_inv), .inf_i(s1_inf),
    .snan_i(s1_snan), .qnan_i(s1_qnan), .anan_sign_i(s1_anan),
    .rdy_o(s2_rdy), .pp_ll_o(s2_pp_ll), .pp_lh_o(s2_pp_lh),
    .pp_hl_o(s2_pp_hl), .pp_hh_o(s2_pp_hh), .shr_o(s2_shr),
    .exp10rx_o(s2_exp10rx), .exp10c_o(s2_exp10c), .sign_o(s2_sign),
    .inv_o(s2_inv), .inf_o(s2_inf), .snan_o(s2_snan), .qnan_o(s2_qnan),
    .anan_sign_o(s2_anan)
  );

  fpu_mul_sum u_sum (
    .clk, .rst, .flush_i, .adv_i, .rdy_i(s2_rdy),
    .pp_ll_i(s2_pp_ll), .pp_lh_i(s2_pp_lh), .pp_hl_i(s2_pp_hl), .pp_hh_i(s2_pp_hh),
    .shr_i(s2_shr), .exp10rx_i(s2_exp10rx), .exp10c_i(s2_exp10c), .sign_i(s2_sign),
    .inv_i(s2_inv), .inf_i(s2_inf), .snan_i(s2_snan), .qnan_i(s2_qnan),
    .anan_sign_i(s2_anan),
    .rdy_o, .sign_o, .shr_o, .exp10shr_o, .exp10sh0_o, .fract28_o,
    .inv_o, .inf_o, .snan_o, .qnan_o, .anan_sign_o
  );

endmodule
